/* verilog/rgbd_cfg_pkg.sv */
/*
 * Input-side widths and types for the RGB-D least-squares row pipeline.
 * Intensities are unsigned; gradients, sigma and point coordinates are
 * two's complement. Focal lengths are unsigned integers in pixel units.
 * The point must already be transformed into the second frame.
 */
package rgbd_cfg_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int RGB_BW   = 8;
    localparam int GRAD_BW  = RGB_BW + 1;
    localparam int CLOUD_BW = 16;
    localparam int FOCAL_BW = 16;

    // ==================================================
    // per-pixel inputs
    // ==================================================
    typedef struct packed {
        logic        [RGB_BW-1:0]  rgb0;
        logic        [RGB_BW-1:0]  rgb1;
        logic signed [GRAD_BW-1:0] grad_x;
        logic signed [GRAD_BW-1:0] grad_y;
        logic signed [GRAD_BW-1:0] sigma;
    } rgbd_sample_t;

    typedef struct packed {
        logic signed [CLOUD_BW-1:0] x;
        logic signed [CLOUD_BW-1:0] y;
        logic signed [CLOUD_BW-1:0] z;
    } point_t;

    // camera intrinsics, expected to stay constant over a frame
    typedef struct packed {
        logic [FOCAL_BW-1:0] fx;
        logic [FOCAL_BW-1:0] fy;
    } intrinsics_t;

    typedef struct packed {
        logic frame_start;
        logic frame_end;
        logic valid;
        logic corresps_valid;
    } frame_flags_t;

endpackage

/* verilog/lsm_pkg.sv */
/*
 * Output-side widths and types for the least-squares row pipeline.
 * Coefficients are signed fixed point with FRAC_BW fraction bits and
 * wrap silently at COEF_BW. The statistics accumulators also wrap, so
 * a frame must stay below 2^COUNT_BW working pixels.
 */
package lsm_pkg;

    // ==================================================
    // fixed point and pipeline
    // ==================================================
    localparam int FRAC_BW     = 8;
    localparam int COEF_BW     = 32;
    localparam int ROW_LATENCY = 6;

    // frame statistics
    localparam int SUMSQ_BW = 40;
    localparam int COUNT_BW = 20;

    // ==================================================
    // results
    // ==================================================
    // one row of the normal equations, A0..A2 rotation, A3..A5 translation
    typedef struct packed {
        logic signed [COEF_BW-1:0] a0;
        logic signed [COEF_BW-1:0] a1;
        logic signed [COEF_BW-1:0] a2;
        logic signed [COEF_BW-1:0] a3;
        logic signed [COEF_BW-1:0] a4;
        logic signed [COEF_BW-1:0] a5;
        logic signed [COEF_BW-1:0] diff_div_w;
    } lsm_row_t;

    typedef struct packed {
        logic [SUMSQ_BW-1:0] sum_sq;
        logic [COUNT_BW-1:0] count;
    } lsm_stats_t;

endpackage

/* verilog/delay_line.sv */
/*
 * Fixed-length shift register for aligning pipeline data.
 * STAGES must be at least 1. All stages clear to zero on reset.
 */
`timescale 1ns/1ps

module delay_line #(
    parameter int WIDTH  = 8,
    parameter int STAGES = 1
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data
);

    logic [STAGES-1:0][WIDTH-1:0] pipe_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pipe_q <= '0;
        end else begin
            pipe_q[0] <= i_data;
            for (int i = 1; i < STAGES; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    // last stage drives the output
    assign o_data = pipe_q[STAGES-1];

endmodule

/* verilog/photometric_residual.sv */
/*
 * Photometric residual path. Weight appears 2 cycles after the sample,
 * the normalized residual after ROW_LATENCY cycles, statistics after 2.
 * A zero weight divides as 1. i_update_done drops the sample of its own
 * cycle and any sample still one stage in flight.
 */
`timescale 1ns/1ps

module photometric_residual
    import rgbd_cfg_pkg::*;
    import lsm_pkg::*;
(
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  rgbd_sample_t              i_sample,
    input  logic                      i_work,
    input  logic                      i_update_done,
    output logic signed [GRAD_BW:0]   o_weight,
    output logic signed [COEF_BW-1:0] o_diff_div_w,
    output lsm_stats_t                o_stats
);

    logic signed [GRAD_BW-1:0]  diff;
    logic signed [GRAD_BW-1:0]  diff_d1;
    logic signed [GRAD_BW-1:0]  sigma_d1;
    logic                       work_d1;
    logic signed [GRAD_BW-1:0]  diff_abs;
    logic signed [GRAD_BW:0]    weight;
    logic signed [GRAD_BW-1:0]  diff_d2;
    logic signed [GRAD_BW:0]    weight_d2;
    logic signed [COEF_BW-1:0]  div_num;
    logic signed [COEF_BW-1:0]  div_den;
    logic signed [COEF_BW-1:0]  quot_d3;
    logic signed [SUMSQ_BW-1:0] diff_ext;
    logic signed [SUMSQ_BW-1:0] diff_sq;
    lsm_stats_t                 stats_q;

    // ==================================================
    // residual and weight
    // ==================================================
    assign diff     = $signed({1'b0, i_sample.rgb0}) - $signed({1'b0, i_sample.rgb1});
    assign diff_abs = diff_d1[GRAD_BW-1] ? -diff_d1 : diff_d1;
    assign weight   = sigma_d1 + diff_abs;

    // diff scaled to fixed point over the guarded weight
    assign div_num = COEF_BW'(diff_d2) <<< FRAC_BW;
    assign div_den = (weight_d2 == '0) ? COEF_BW'(1) : COEF_BW'(weight_d2);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            diff_d1   <= '0;
            sigma_d1  <= '0;
            diff_d2   <= '0;
            weight_d2 <= '0;
            quot_d3   <= '0;
        end else begin
            diff_d1   <= diff;
            sigma_d1  <= i_sample.sigma;
            diff_d2   <= diff_d1;
            weight_d2 <= weight;
            quot_d3   <= div_num / div_den;
        end
    end

    // quotient waits for the jacobian path
    delay_line #(
        .WIDTH  (COEF_BW),
        .STAGES (ROW_LATENCY - 3)
    ) u_quot_dly (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (quot_d3),
        .o_data  (o_diff_div_w)
    );

    // ==================================================
    // frame statistics
    // ==================================================
    assign diff_ext = diff_d1;
    assign diff_sq  = diff_ext * diff_ext;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            work_d1 <= 1'b0;
            stats_q <= '0;
        end else begin
            work_d1 <= i_work && !i_update_done;
            if (i_update_done) begin
                stats_q <= '0;
            end else if (work_d1) begin
                stats_q.sum_sq <= stats_q.sum_sq + diff_sq;
                stats_q.count  <= stats_q.count + 1'b1;
            end
        end
    end

    assign o_weight = weight_d2;
    assign o_stats  = stats_q;

endmodule

/* verilog/jacobian_row.sv */
/*
 * Jacobian path. Inputs are expected 2 cycles after the pixel enters the
 * top level; A0..A5 leave 4 cycles later. A zero z*w or z divides as 1.
 * Intermediate terms are sized so only the final COEF_BW truncation wraps.
 * Focal lengths are sampled without delay and must be quasi-static.
 */
`timescale 1ns/1ps

module jacobian_row
    import rgbd_cfg_pkg::*;
    import lsm_pkg::*;
(
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic signed [GRAD_BW-1:0] i_grad_x,
    input  logic signed [GRAD_BW-1:0] i_grad_y,
    input  logic signed [GRAD_BW:0]   i_weight,
    input  point_t                    i_point,
    input  intrinsics_t               i_intr,
    output logic signed [COEF_BW-1:0] o_a0,
    output logic signed [COEF_BW-1:0] o_a1,
    output logic signed [COEF_BW-1:0] o_a2,
    output logic signed [COEF_BW-1:0] o_a3,
    output logic signed [COEF_BW-1:0] o_a4,
    output logic signed [COEF_BW-1:0] o_a5
);

    logic signed [FOCAL_BW:0]                 fx_s;
    logic signed [FOCAL_BW:0]                 fy_s;
    logic signed [GRAD_BW+CLOUD_BW:0]         zw;
    logic signed [GRAD_BW+CLOUD_BW:0]         zw_d3;
    logic signed [GRAD_BW+FOCAL_BW:0]         gfx_d3;
    logic signed [GRAD_BW+FOCAL_BW:0]         gfy_d3;
    logic signed [GRAD_BW+FOCAL_BW+FRAC_BW:0] v_num0;
    logic signed [GRAD_BW+FOCAL_BW+FRAC_BW:0] v_num1;
    logic signed [GRAD_BW+FOCAL_BW+FRAC_BW:0] v_den;
    logic signed [GRAD_BW+FOCAL_BW+FRAC_BW:0] v0_q;
    logic signed [GRAD_BW+FOCAL_BW+FRAC_BW:0] v1_q;
    logic signed [COEF_BW-1:0]                v0_d4;
    logic signed [COEF_BW-1:0]                v1_d4;
    point_t                                   point_d4;
    point_t                                   point_d5;
    logic signed [COEF_BW+CLOUD_BW:0]         v0x;
    logic signed [COEF_BW+CLOUD_BW:0]         v1y;
    logic signed [COEF_BW+CLOUD_BW:0]         z_div;
    logic signed [COEF_BW+CLOUD_BW:0]         v2_q;
    logic signed [COEF_BW-1:0]                v2_d5;
    logic signed [COEF_BW-1:0]                v0_d5;
    logic signed [COEF_BW-1:0]                v1_d5;
    logic signed [COEF_BW+CLOUD_BW:0]         cross0;
    logic signed [COEF_BW+CLOUD_BW:0]         cross1;
    logic signed [COEF_BW+CLOUD_BW:0]         cross2;
    logic signed [COEF_BW+CLOUD_BW:0]         cross0_sh;
    logic signed [COEF_BW+CLOUD_BW:0]         cross1_sh;
    logic signed [COEF_BW+CLOUD_BW:0]         cross2_sh;

    // ==================================================
    // zw and gradient times focal length
    // ==================================================
    assign fx_s = {1'b0, i_intr.fx};
    assign fy_s = {1'b0, i_intr.fy};
    assign zw   = i_weight * i_point.z;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            zw_d3  <= '0;
            gfx_d3 <= '0;
            gfy_d3 <= '0;
        end else begin
            zw_d3  <= (zw == '0) ? 1 : zw;
            gfx_d3 <= i_grad_x * fx_s;
            gfy_d3 <= i_grad_y * fy_s;
        end
    end

    // v0, v1 = grad * f * 2^FRAC / zw
    assign v_num0 = gfx_d3 <<< FRAC_BW;
    assign v_num1 = gfy_d3 <<< FRAC_BW;
    assign v_den  = zw_d3;
    assign v0_q   = v_num0 / v_den;
    assign v1_q   = v_num1 / v_den;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            v0_d4 <= '0;
            v1_d4 <= '0;
        end else begin
            v0_d4 <= v0_q[COEF_BW-1:0];
            v1_d4 <= v1_q[COEF_BW-1:0];
        end
    end

    delay_line #(
        .WIDTH  ($bits(point_t)),
        .STAGES (2)
    ) u_point_d4 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_point),
        .o_data  (point_d4)
    );

    // ==================================================
    // v2 = -(v0*x + v1*y) / z
    // ==================================================
    assign v0x   = v0_d4 * point_d4.x;
    assign v1y   = v1_d4 * point_d4.y;
    assign z_div = (point_d4.z == '0) ? 1 : point_d4.z;
    assign v2_q  = -(v0x + v1y) / z_div;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            v2_d5 <= '0;
        end else begin
            v2_d5 <= v2_q[COEF_BW-1:0];
        end
    end

    delay_line #(
        .WIDTH  ($bits(point_t)),
        .STAGES (1)
    ) u_point_d5 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (point_d4),
        .o_data  (point_d5)
    );

    delay_line #(
        .WIDTH  (2 * COEF_BW),
        .STAGES (1)
    ) u_v01_d5 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  ({v0_d4, v1_d4}),
        .o_data  ({v0_d5, v1_d5})
    );

    // ==================================================
    // cross products, back to FRAC_BW fraction bits
    // ==================================================
    assign cross0 = point_d5.y * v2_d5 - point_d5.z * v1_d5;
    assign cross1 = point_d5.z * v0_d5 - point_d5.x * v2_d5;
    assign cross2 = point_d5.x * v1_d5 - point_d5.y * v0_d5;

    assign cross0_sh = cross0 >>> FRAC_BW;
    assign cross1_sh = cross1 >>> FRAC_BW;
    assign cross2_sh = cross2 >>> FRAC_BW;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_a0 <= '0;
            o_a1 <= '0;
            o_a2 <= '0;
            o_a3 <= '0;
            o_a4 <= '0;
            o_a5 <= '0;
        end else begin
            o_a0 <= cross0_sh[COEF_BW-1:0];
            o_a1 <= cross1_sh[COEF_BW-1:0];
            o_a2 <= cross2_sh[COEF_BW-1:0];
            o_a3 <= v0_d5;
            o_a4 <= v1_d5;
            o_a5 <= v2_d5;
        end
    end

endmodule

/* verilog/lsm_row_top.sv */
/*
 * One least-squares row per pixel, no handshake and no back-pressure.
 * A new pixel may enter every cycle; o_row and o_flags follow the inputs
 * by ROW_LATENCY cycles. o_row is only meaningful when the delayed flags
 * show valid and corresps_valid. o_stats trails a working pixel by 2.
 */
`timescale 1ns/1ps

module lsm_row_top
    import rgbd_cfg_pkg::*;
    import lsm_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  frame_flags_t i_flags,
    input  rgbd_sample_t i_sample,
    input  point_t       i_point,
    input  intrinsics_t  i_intr,
    input  logic         i_update_done,
    output frame_flags_t o_flags,
    output lsm_row_t     o_row,
    output lsm_stats_t   o_stats
);

    // jacobian operands waiting for the weight
    typedef struct packed {
        logic signed [GRAD_BW-1:0] grad_x;
        logic signed [GRAD_BW-1:0] grad_y;
        point_t                    point;
    } jac_in_t;

    logic                      work;
    jac_in_t                   jac_in;
    jac_in_t                   jac_in_d2;
    logic signed [GRAD_BW:0]   weight_d2;
    logic signed [COEF_BW-1:0] diff_div_w;
    logic signed [COEF_BW-1:0] a0;
    logic signed [COEF_BW-1:0] a1;
    logic signed [COEF_BW-1:0] a2;
    logic signed [COEF_BW-1:0] a3;
    logic signed [COEF_BW-1:0] a4;
    logic signed [COEF_BW-1:0] a5;

    assign work = i_flags.valid && i_flags.corresps_valid;

    photometric_residual u_residual (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_sample      (i_sample),
        .i_work        (work),
        .i_update_done (i_update_done),
        .o_weight      (weight_d2),
        .o_diff_div_w  (diff_div_w),
        .o_stats       (o_stats)
    );

    assign jac_in.grad_x = i_sample.grad_x;
    assign jac_in.grad_y = i_sample.grad_y;
    assign jac_in.point  = i_point;

    // match the 2-cycle weight latency
    delay_line #(
        .WIDTH  ($bits(jac_in_t)),
        .STAGES (2)
    ) u_jac_in_dly (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (jac_in),
        .o_data  (jac_in_d2)
    );

    jacobian_row u_jacobian (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_grad_x (jac_in_d2.grad_x),
        .i_grad_y (jac_in_d2.grad_y),
        .i_weight (weight_d2),
        .i_point  (jac_in_d2.point),
        .i_intr   (i_intr),
        .o_a0     (a0),
        .o_a1     (a1),
        .o_a2     (a2),
        .o_a3     (a3),
        .o_a4     (a4),
        .o_a5     (a5)
    );

    delay_line #(
        .WIDTH  ($bits(frame_flags_t)),
        .STAGES (ROW_LATENCY)
    ) u_flags_dly (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_flags),
        .o_data  (o_flags)
    );

    always_comb begin
        o_row.a0         = a0;
        o_row.a1         = a1;
        o_row.a2         = a2;
        o_row.a3         = a3;
        o_row.a4         = a4;
        o_row.a5         = a5;
        o_row.diff_div_w = diff_div_w;
    end

endmodule

/* testbench/lsm_row_chk.sv */
/*
 * Assertions bound into lsm_row_top. Flag alignment is only checked once
 * ROW_LATENCY edges have passed since reset release.
 */
`timescale 1ns/1ps

module lsm_row_chk
    import rgbd_cfg_pkg::*;
    import lsm_pkg::*;
(
    input logic         i_clk,
    input logic         i_rst_n,
    input frame_flags_t i_flags,
    input logic         i_update_done,
    input frame_flags_t i_out_flags,
    input lsm_row_t     i_row,
    input lsm_stats_t   i_stats
);

    int   run_cycles;
    logic in_reset_q = 1'b0;

    // edges since reset release, saturating
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_cycles <= 0;
        end else if (run_cycles < ROW_LATENCY) begin
            run_cycles <= run_cycles + 1;
        end
    end

    always @(posedge i_clk) begin
        in_reset_q <= !i_rst_n;
    end

    a_flags_delay: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (run_cycles >= ROW_LATENCY) |-> (i_out_flags == $past(i_flags, ROW_LATENCY)))
        else $error("o_flags differ from i_flags of ROW_LATENCY cycles before");

    a_stats_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_update_done |=> (i_stats == '0))
        else $error("o_stats not cleared after update done");

    a_reset_zero: assert property (@(posedge i_clk)
        (!i_rst_n && in_reset_q) |-> (i_out_flags == '0 && i_row == '0 && i_stats == '0))
        else $error("outputs not zero during reset");

endmodule

/* testbench/tb_lsm_row.sv */
/*
 * Testbench for lsm_row_top. Random pixels come from a 32-bit Galois LFSR
 * and are checked against a 64-bit reference model of the row arithmetic.
 * Intrinsics change only while the pipeline is empty. The statistics model
 * expects the cycle before an update-done pulse to carry no working pixel.
 */
`timescale 1ns/1ps

module tb_lsm_row
    import rgbd_cfg_pkg::*;
    import lsm_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;

    logic         i_clk;
    logic         i_rst_n;
    frame_flags_t i_flags;
    rgbd_sample_t i_sample;
    point_t       i_point;
    intrinsics_t  i_intr;
    logic         i_update_done;
    frame_flags_t o_flags;
    lsm_row_t     o_row;
    lsm_stats_t   o_stats;

    logic [31:0]         lfsr_state;
    lsm_row_t            row_q[$];
    frame_flags_t        flag_hist[$];
    logic [SUMSQ_BW-1:0] model_sum_sq;
    logic [COUNT_BW-1:0] model_count;
    logic                check_en;
    logic                timed_out;
    int                  err_count;
    int                  check_count;
    int                  test_count;
    int                  test_fails;
    int                  test_errs_start;

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    lsm_row_top u_dut (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flags       (i_flags),
        .i_sample      (i_sample),
        .i_point       (i_point),
        .i_intr        (i_intr),
        .i_update_done (i_update_done),
        .o_flags       (o_flags),
        .o_row         (o_row),
        .o_stats       (o_stats)
    );

    bind lsm_row_top lsm_row_chk u_chk (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flags       (i_flags),
        .i_update_done (i_update_done),
        .i_out_flags   (o_flags),
        .i_row         (o_row),
        .i_stats       (o_stats)
    );

    // ==================================================
    // random numbers and reference model
    // ==================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic longint wrap32(input longint v);
        return longint'($signed(v[31:0]));
    endfunction

    function automatic lsm_row_t model_row(input rgbd_sample_t s, input point_t p,
                                           input intrinsics_t f);
        longint   scale;
        longint   diff;
        longint   w;
        longint   zw;
        longint   zdiv;
        longint   v0;
        longint   v1;
        longint   v2;
        lsm_row_t r;
        scale = longint'(1) <<< FRAC_BW;
        diff  = longint'(s.rgb0) - longint'(s.rgb1);
        w     = longint'(s.sigma) + ((diff < 0) ? -diff : diff);
        r.diff_div_w = COEF_BW'((diff * scale) / ((w == 0) ? 1 : w));
        zw = w * longint'(p.z);
        if (zw == 0) zw = 1;
        v0   = wrap32((longint'(s.grad_x) * longint'(f.fx) * scale) / zw);
        v1   = wrap32((longint'(s.grad_y) * longint'(f.fy) * scale) / zw);
        zdiv = (p.z == 0) ? 1 : longint'(p.z);
        v2   = wrap32(-(v0 * longint'(p.x) + v1 * longint'(p.y)) / zdiv);
        r.a0 = COEF_BW'((longint'(p.y) * v2 - longint'(p.z) * v1) >>> FRAC_BW);
        r.a1 = COEF_BW'((longint'(p.z) * v0 - longint'(p.x) * v2) >>> FRAC_BW);
        r.a2 = COEF_BW'((longint'(p.x) * v1 - longint'(p.y) * v0) >>> FRAC_BW);
        r.a3 = COEF_BW'(v0);
        r.a4 = COEF_BW'(v1);
        r.a5 = COEF_BW'(v2);
        return r;
    endfunction

    function automatic rgbd_sample_t random_sample(input logic zero_w);
        rgbd_sample_t s;
        int           d;
        s.rgb0   = RGB_BW'(rand_bits(RGB_BW));
        s.rgb1   = RGB_BW'(rand_bits(RGB_BW));
        s.grad_x = GRAD_BW'(rand_bits(GRAD_BW));
        s.grad_y = GRAD_BW'(rand_bits(GRAD_BW));
        s.sigma  = GRAD_BW'(rand_bits(GRAD_BW));
        // sigma = -|diff| gives a zero weight
        if (zero_w) begin
            d = int'(s.rgb0) - int'(s.rgb1);
            s.sigma = GRAD_BW'((d < 0) ? d : -d);
        end
        return s;
    endfunction

    function automatic point_t random_point(input logic zero_z);
        point_t p;
        p.x = CLOUD_BW'(rand_bits(CLOUD_BW));
        p.y = CLOUD_BW'(rand_bits(CLOUD_BW));
        p.z = zero_z ? '0 : CLOUD_BW'(rand_bits(CLOUD_BW));
        return p;
    endfunction

    function automatic frame_flags_t random_flags(input logic working);
        frame_flags_t f;
        f = 4'(rand_bits(4));
        if (working) begin
            f.valid          = 1'b1;
            f.corresps_valid = 1'b1;
        end
        return f;
    endfunction

    // ==================================================
    // checks
    // ==================================================
    task automatic check_value(input string name, input longint got, input longint exp);
        check_count++;
        if (got != exp) begin
            err_count++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input lsm_row_t exp);
        check_value("o_row.a0", o_row.a0, exp.a0);
        check_value("o_row.a1", o_row.a1, exp.a1);
        check_value("o_row.a2", o_row.a2, exp.a2);
        check_value("o_row.a3", o_row.a3, exp.a3);
        check_value("o_row.a4", o_row.a4, exp.a4);
        check_value("o_row.a5", o_row.a5, exp.a5);
        check_value("o_row.diff_div_w", o_row.diff_div_w, exp.diff_div_w);
    endtask

    task automatic check_stats();
        check_value("o_stats.sum_sq", longint'(o_stats.sum_sq), longint'(model_sum_sq));
        check_value("o_stats.count", longint'(o_stats.count), longint'(model_count));
    endtask

    // outputs are stable at the falling edge
    always @(negedge i_clk) begin : output_monitor
        frame_flags_t exp_flags;
        lsm_row_t     exp_row;
        if (check_en) begin
            if (flag_hist.size() == ROW_LATENCY) begin
                exp_flags = flag_hist.pop_front();
                check_value("o_flags", longint'(o_flags), longint'(exp_flags));
            end
            flag_hist.push_back(i_flags);
            if (o_flags.valid && o_flags.corresps_valid) begin
                if (row_q.size() == 0) begin
                    err_count++;
                    $display("a working row came out at %0t with none expected", $time);
                end else begin
                    exp_row = row_q.pop_front();
                    check_row(exp_row);
                end
            end
        end
    end

    // ==================================================
    // stimulus
    // ==================================================
    task automatic drive_pixel(input frame_flags_t f, input rgbd_sample_t s,
                               input point_t p, input logic upd);
        @(posedge i_clk);
        #1;
        i_flags       = f;
        i_sample      = s;
        i_point       = p;
        i_update_done = upd;
        if (upd) begin
            model_sum_sq = '0;
            model_count  = '0;
        end else if (f.valid && f.corresps_valid) begin
            model_sum_sq += SUMSQ_BW'((int'(s.rgb0) - int'(s.rgb1)) ** 2);
            model_count  += 1'b1;
        end
        if (f.valid && f.corresps_valid) begin
            row_q.push_back(model_row(s, p, i_intr));
        end
    endtask

    task automatic drive_idle();
        drive_pixel('0, '0, '0, 1'b0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (row_q.size() != 0 && n < TIMEOUT_CYCLES) begin
            drive_idle();
            n++;
        end
        if (row_q.size() != 0) begin
            $display("timeout: %0d expected rows never came out", row_q.size());
            timed_out = 1'b1;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_errs_start && !timed_out) begin
            $display("test %s: ok", name);
        end else begin
            test_fails++;
            $display("test %s: %0d errors", name, err_count - test_errs_start);
        end
        test_errs_start = err_count;
    endtask

    task automatic run_residual_test();
        @(posedge i_clk);
        #1;
        i_intr = 32'(rand_bits(32));
        for (int i = 0; i < 40; i++) begin
            drive_pixel(random_flags(1'b1), random_sample(i % 4 == 0),
                        random_point(1'b0), 1'b0);
        end
        wait_drain();
        end_test("residual");
    endtask

    task automatic run_jacobian_test();
        for (int r = 0; r < 3 && !timed_out; r++) begin
            i_intr = 32'(rand_bits(32));
            for (int i = 0; i < 20; i++) begin
                drive_pixel(random_flags(1'b1), random_sample(i % 5 == 1),
                            random_point(i % 5 == 3), 1'b0);
            end
            wait_drain();
        end
        end_test("jacobian");
    endtask

    task automatic run_flags_test();
        for (int i = 0; i < 60; i++) begin
            drive_pixel(random_flags(1'b0), random_sample(1'b0), random_point(1'b0), 1'b0);
        end
        wait_drain();
        end_test("flags");
    endtask

    task automatic run_stats_test();
        frame_flags_t f;
        for (int i = 0; i < 30; i++) begin
            f = random_flags(1'b0);
            f.frame_start = (i == 0);
            f.frame_end   = (i == 29);
            drive_pixel(f, random_sample(1'b0), random_point(1'b0), 1'b0);
        end
        drive_idle();
        drive_idle();
        @(negedge i_clk);
        check_stats();
        wait_drain();
        end_test("stats");
    endtask

    task automatic run_clear_test();
        drive_idle();
        // working pixel in the pulse cycle is dropped
        drive_pixel(random_flags(1'b1), random_sample(1'b0), random_point(1'b0), 1'b1);
        drive_idle();
        @(negedge i_clk);
        check_stats();
        for (int i = 0; i < 10; i++) begin
            drive_pixel(random_flags(1'b0), random_sample(1'b0), random_point(1'b0), 1'b0);
        end
        drive_idle();
        drive_idle();
        @(negedge i_clk);
        check_stats();
        wait_drain();
        end_test("clear");
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        lfsr_state      = 32'h0987ea5b;
        i_rst_n         = 1'b0;
        i_flags         = '0;
        i_sample        = '0;
        i_point         = '0;
        i_intr          = '0;
        i_update_done   = 1'b0;
        model_sum_sq    = '0;
        model_count     = '0;
        check_en        = 1'b0;
        timed_out       = 1'b0;
        err_count       = 0;
        check_count     = 0;
        test_count      = 0;
        test_fails      = 0;
        test_errs_start = 0;
        repeat (8) @(posedge i_clk);
        #1;
        i_rst_n  = 1'b1;
        check_en = 1'b1;
        @(negedge i_clk);
        check_value("o_flags", longint'(o_flags), 0);
        check_row('0);
        check_stats();
        end_test("reset");
        run_residual_test();
        if (!timed_out) run_jacobian_test();
        if (!timed_out) run_flags_test();
        if (!timed_out) run_stats_test();
        if (!timed_out) run_clear_test();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, test_fails, check_count, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/rgbd_cfg_pkg.sv
verilog/lsm_pkg.sv
verilog/delay_line.sv
verilog/photometric_residual.sv
verilog/jacobian_row.sv
verilog/lsm_row_top.sv
testbench/lsm_row_chk.sv
testbench/tb_lsm_row.sv

/* Makefile */
# Verilator build and run of the least-squares row testbench

VERILATOR ?= verilator
TOP       ?= tb_lsm_row
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
